/* list.f */
+incdir+source
source/dcache_pkg.sv
source/dcache_rst_block.sv
source/dcache_req_decode.sv
source/dcache_lookup.sv
source/dcache_resp.sv
source/dcache_top.sv
testbench/dcache_clk_gen.sv
testbench/tb_dcache.sv

/* run.sh */
#!/bin/sh
# Compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_dcache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

output=$(./obj_dir/Vtb_dcache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1

/* testbench/tb_dcache.sv */
// Data cache testbench
// Memory model, reference model, stimulus, response compare and watchdog

`timescale 1ns/1ps
`include "dcache_macros.svh"

module tb_dcache
  import dcache_pkg::*;
();

  localparam logic [31:0] Seed = 32'hee07_e459;
  localparam int unsigned TotalReqs = 312;
  // Sweep and reset cycles plus a budget of 200 cycles per request
  localparam int unsigned WatchdogCycles = `DCACHE_SETS + 8 + 200 * TotalReqs;
  // Negedge of acceptance to negedge of the response strobe
  localparam int unsigned HitLatency = 3;
  localparam logic [31:0] AddrA = 32'h0000_1040;
  localparam logic [31:0] AddrB = 32'h0000_2088;
  // Same set with different tags
  localparam logic [31:0] AddrX = 32'h0000_3104;
  localparam logic [31:0] AddrY = 32'h0005_3104;
  localparam logic [31:0] RandBase = 32'h0001_0000;

  // Expected response of one accepted request
  typedef struct packed {
    logic        we;
    logic        miss;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] cyc;
  } exp_t;

  // Expected memory strobe
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] data;
  } mem_exp_t;

  logic     clk_i;
  logic     rst_ni;
  cpu_req_t cpu_req;
  logic     busy;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  // Backing memory and reference state keyed by word address
  logic [31:0]              mem_words [logic [29:0]];
  logic [31:0]              ref_mem [logic [29:0]];
  logic [`DCACHE_SETS-1:0]  ref_valid = '0;
  logic [`DCACHE_TAG_W-1:0] ref_tag  [`DCACHE_SETS];
  logic [31:0]              ref_data [`DCACHE_SETS];

  exp_t        rsp_q[$];
  mem_exp_t    mem_q[$];
  int unsigned cyc = 0;
  int unsigned sent = 0;
  int unsigned accepted = 0;
  int unsigned rsp_seen = 0;
  int unsigned rd_strobes = 0;
  int unsigned wr_strobes = 0;
  int unsigned mon_errors = 0;
  int unsigned seq_errors = 0;

  dcache_clk_gen dcache_clk_gen_inst (
    .clk   (clk_i),
    .rst_n (rst_ni)
  );

  dcache_top dcache_top_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cpu_req (cpu_req),
    .busy    (busy),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Content of a word never written depends on the whole address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr ^ 32'hc3a5_0f96) * 32'h9e37_79b1;
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return ref_mem.exists(addr[31:2]) ? ref_mem[addr[31:2]] : fill_word(addr);
  endfunction

  // Reference model advances the mirror and memory in acceptance order
  function automatic exp_t predict(input cpu_req_t req, input logic [31:0] acc_cyc);
    exp_t                     e;
    logic [`DCACHE_IDX_W-1:0] idx;
    logic [`DCACHE_TAG_W-1:0] tag;
    logic                     hit;
    idx = req.addr[`DCACHE_OFF_W +: `DCACHE_IDX_W];
    tag = req.addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
    hit = ref_valid[idx] && (ref_tag[idx] == tag);
    e.we   = req.we;
    e.addr = req.addr;
    e.cyc  = acc_cyc;
    e.miss = !hit;
    if (req.we) begin
      // Write-through updates the line only on a hit
      e.data = req.wdata;
      ref_mem[req.addr[31:2]] = req.wdata;
      if (hit) begin
        ref_data[idx] = req.wdata;
      end
    end else if (hit) begin
      e.data = ref_data[idx];
    end else begin
      e.data = ref_word(req.addr);
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
      ref_data[idx]  = e.data;
    end
    return e;
  endfunction

  function automatic int unsigned total_errors();
    return mon_errors + seq_errors;
  endfunction

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // Memory model answers reads after 1 to 4 cycles and applies writes at once
  initial begin : memory_model
    logic [31:0] rng;
    logic [31:0] rd_addr;
    int unsigned delay;
    rng = Seed;
    mem_rsp = '0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req.valid) begin
        if (mem_req.we) begin
          mem_words[mem_req.addr[31:2]] = mem_req.data;
        end else begin
          rd_addr = mem_req.addr;
          rng = xorshift32(rng);
          delay = 1 + rng % 4;
          repeat (delay) @(posedge clk_i);
          #1;
          mem_rsp.data = mem_words.exists(rd_addr[31:2]) ?
                         mem_words[rd_addr[31:2]] : fill_word(rd_addr);
          mem_rsp.valid = 1'b1;
          @(posedge clk_i);
          #1;
          mem_rsp.valid = 1'b0;
        end
      end
    end
  end

  // Compare process samples mid-cycle where all DUT outputs are settled
  always @(negedge clk_i) begin : compare
    exp_t        e;
    mem_exp_t    m;
    logic [31:0] lat;
    if (rst_ni) begin
      if (mem_req.valid) begin
        if (mem_req.we) begin
          wr_strobes++;
        end else begin
          rd_strobes++;
        end
        if (mem_q.size() == 0) begin
          $display("Memory strobe at 0x%08h with no operation waiting for one", mem_req.addr);
          mon_errors++;
        end else begin
          m = mem_q.pop_front();
          assert (mem_req.we == m.we) else begin
            $display("** Error: mem_req.we = 0x%0h, expected 0x%0h", mem_req.we, m.we);
            mon_errors++;
          end
          assert (mem_req.addr == m.addr) else begin
            $display("** Error: mem_req.addr = 0x%08h, expected 0x%08h", mem_req.addr, m.addr);
            mon_errors++;
          end
          assert (!m.we || mem_req.data == m.data) else begin
            $display("** Error: mem_req.data = 0x%08h, expected 0x%08h", mem_req.data, m.data);
            mon_errors++;
          end
        end
      end
      if (cpu_rsp.valid) begin
        rsp_seen++;
        if (rsp_q.size() == 0) begin
          $display("Response strobe with no request outstanding");
          mon_errors++;
        end else begin
          e = rsp_q.pop_front();
          lat = cyc - e.cyc;
          assert (cpu_rsp.ack == e.we) else begin
            $display("** Error: cpu_rsp.ack = 0x%0h, expected 0x%0h", cpu_rsp.ack, e.we);
            mon_errors++;
          end
          assert (e.we || cpu_rsp.rdata == e.data) else begin
            $display("** Error: cpu_rsp.rdata = 0x%08h, expected 0x%08h at 0x%08h",
                     cpu_rsp.rdata, e.data, e.addr);
            mon_errors++;
          end
          // Only a load miss waits for memory
          if (!e.we && e.miss) begin
            assert (lat > HitLatency) else begin
              $display("Load at 0x%08h answered after %0d cycles, too fast for a miss",
                       e.addr, lat);
              mon_errors++;
            end
          end else begin
            assert (lat == HitLatency) else begin
              $display("Request at 0x%08h answered after %0d cycles instead of %0d",
                       e.addr, lat, HitLatency);
              mon_errors++;
            end
          end
        end
      end
      // Accepted on the coming edge
      if (cpu_req.valid && !busy) begin
        accepted++;
        e = predict(cpu_req, cyc);
        rsp_q.push_back(e);
        if (e.we || e.miss) begin
          m.we   = e.we;
          m.addr = e.addr;
          m.data = e.data;
          mem_q.push_back(m);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout after %0d cycles, the run did not complete", WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  // Drive one request after the edge and hold it until accepted
  task automatic send(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    cpu_req.valid = 1'b1;
    cpu_req.we    = we;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    sent++;
    @(negedge clk_i);
    while (busy) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    cpu_req.valid = 1'b0;
  endtask

  // Wait until every response and memory strobe is accounted for
  task automatic drain();
    @(posedge clk_i);
    while (rsp_q.size() != 0 || mem_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input string name, input int unsigned err0);
    $display("Test %-16s done, %0d errors", name, total_errors() - err0);
  endtask

  initial begin : stimulus
    logic [31:0] rng;
    logic [31:0] r;
    logic [31:0] addr;
    int unsigned err0;
    int unsigned rd0;
    int unsigned wr0;
    int unsigned n;
    rng = Seed;
    cpu_req = '0;

    // Reset sweep with busy counted on the negedges after release
    @(posedge rst_ni);
    err0 = total_errors();
    n = 0;
    @(negedge clk_i);
    while (busy) begin
      n++;
      @(negedge clk_i);
    end
    assert (n == `DCACHE_SETS) else begin
      $display("busy was high for %0d edges after reset instead of %0d", n, `DCACHE_SETS);
      seq_errors++;
    end
    assert (rd_strobes + wr_strobes == 0 && rsp_seen == 0) else begin
      $display("Strobe seen on the memory or CPU side during the reset sweep");
      seq_errors++;
    end
    @(posedge clk_i);
    #1;
    report_test("reset sweep", err0);

    // Load miss followed by a hit on the same address
    err0 = total_errors();
    rd0 = rd_strobes;
    send(1'b0, AddrA, '0);
    send(1'b0, AddrA, '0);
    drain();
    assert (rd_strobes - rd0 == 1) else begin
      $display("Miss then hit issued %0d memory reads instead of 1", rd_strobes - rd0);
      seq_errors++;
    end
    report_test("miss then hit", err0);

    // Store miss does not allocate while a store hit updates the line
    err0 = total_errors();
    rd0 = rd_strobes;
    wr0 = wr_strobes;
    send(1'b1, AddrB, 32'hdead_beef);
    send(1'b0, AddrB, '0);
    send(1'b1, AddrB, 32'h1234_5678);
    send(1'b0, AddrB, '0);
    drain();
    assert (wr_strobes - wr0 == 2 && rd_strobes - rd0 == 1) else begin
      $display("Store test issued %0d writes and %0d reads instead of 2 and 1",
               wr_strobes - wr0, rd_strobes - rd0);
      seq_errors++;
    end
    report_test("write-through", err0);

    // Two tags fighting over one set
    err0 = total_errors();
    rd0 = rd_strobes;
    for (int i = 0; i < 6; i++) begin
      send(1'b0, i[0] ? AddrY : AddrX, '0);
    end
    drain();
    assert (rd_strobes - rd0 == 6) else begin
      $display("Conflict test issued %0d memory reads instead of 6", rd_strobes - rd0);
      seq_errors++;
    end
    report_test("conflict", err0);

    // Random loads and stores over 64 words issued back to back
    err0 = total_errors();
    for (int i = 0; i < 300; i++) begin
      rng = xorshift32(rng);
      r = rng;
      addr = RandBase + {24'd0, r[8:3], 2'b00};
      rng = xorshift32(rng);
      send(r[0], addr, rng);
    end
    drain();
    report_test("random mix", err0);

    assert (rsp_seen == sent) else begin
      $display("Requests lost or duplicated, %0d sent, %0d accepted, %0d answered",
               sent, accepted, rsp_seen);
      seq_errors++;
    end
    $display("Requests %0d, responses %0d, memory reads %0d, memory writes %0d, errors %0d",
             sent, rsp_seen, rd_strobes, wr_strobes, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* testbench/dcache_clk_gen.sv */
// Testbench clock and reset source
// 10 ns clock, active-low reset held for the first 8 cycles

`timescale 1ns/1ps

module dcache_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int unsigned ResetCycles = 8;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Release just after an edge, away from the sampling point
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* source/dcache_top.sv */
// Level-one data cache
// Reset sweep, decode, lookup and result stages

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_top
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cpu_req_t cpu_req,
  output logic     busy,
  output cpu_rsp_t cpu_rsp,
  output mem_req_t mem_req,
  input  mem_rsp_t mem_rsp
);

  // Stage links
  rst_req_t                 rst_req;
  dec_op_t                  dec_op;
  logic                     inv;
  logic [`DCACHE_IDX_W-1:0] inv_idx;
  logic                     stall;
  cpu_rsp_t                 hit_op;

  dcache_rst_block dcache_rst_block_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rst_req (rst_req)
  );

  dcache_req_decode dcache_req_decode_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cpu_req (cpu_req),
    .rst_req (rst_req),
    .stall   (stall),
    .busy    (busy),
    .dec_op  (dec_op),
    .inv     (inv),
    .inv_idx (inv_idx)
  );

  dcache_lookup dcache_lookup_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .dec_op  (dec_op),
    .inv     (inv),
    .inv_idx (inv_idx),
    .mem_rsp (mem_rsp),
    .mem_req (mem_req),
    .stall   (stall),
    .hit_op  (hit_op)
  );

  dcache_resp dcache_resp_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .hit_op  (hit_op),
    .cpu_rsp (cpu_rsp)
  );

endmodule

/* source/dcache_resp.sv */
// Data cache result stage
// Registers one response per finished operation toward the CPU

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_resp
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cpu_rsp_t hit_op,
  output cpu_rsp_t cpu_rsp
);

  logic                      vld_q;
  logic                      ack_q;
  logic [`DCACHE_WORD_W-1:0] data_q;

  // Clean one-cycle strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= hit_op.valid;
    end
  end

  // Last response data stays visible between strobes
  always_ff @(posedge clk_i) begin
    if (hit_op.valid) begin
      ack_q  <= hit_op.ack;
      data_q <= hit_op.rdata;
    end
  end

  assign cpu_rsp = '{valid: vld_q, ack: ack_q, rdata: data_q};

  // Back-to-back strobes only for two ops in flight
  a_no_stretch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cpu_rsp.valid && $past(cpu_rsp.valid)) |-> ($past(hit_op.valid) && $past(hit_op.valid, 2)));

endmodule

/* source/dcache_lookup.sv */
// Data cache lookup stage
// Tag, valid and data arrays, hit detection, refill and write-through

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_lookup
  import dcache_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dec_op_t                  dec_op,
  input  logic                     inv,
  input  logic [`DCACHE_IDX_W-1:0] inv_idx,
  input  mem_rsp_t                 mem_rsp,
  output mem_req_t                 mem_req,
  output logic                     stall,
  output cpu_rsp_t                 hit_op
);

  typedef enum logic {
    StIdle,
    StRefill
  } state_t;

  state_t state_d, state_q;

  // Per-set storage
  logic [`DCACHE_SETS-1:0]   valid_q;
  logic [`DCACHE_TAG_W-1:0]  tag_q  [`DCACHE_SETS];
  logic [`DCACHE_WORD_W-1:0] data_q [`DCACHE_SETS];

  logic [`DCACHE_IDX_W-1:0]  idx;
  logic                      hit;
  logic                      do_op;
  logic                      ld_miss;
  logic                      fill;

  logic                      rsp_vld_q;
  logic                      rsp_ack_q;
  logic [`DCACHE_WORD_W-1:0] rsp_data_q;

  logic                      mem_vld_q;
  logic                      mem_we_q;
  logic [`DCACHE_WORD_W-1:0] mem_addr_q;
  logic [`DCACHE_WORD_W-1:0] mem_data_q;

  assign idx = dec_op.addr.fields.idx;
  assign hit = valid_q[idx] && (tag_q[idx] == dec_op.addr.fields.tag);

  // Ops are taken only when no refill is running
  assign do_op   = (state_q == StIdle) && dec_op.valid;
  assign ld_miss = do_op && !dec_op.we && !hit;
  assign fill    = (state_q == StRefill) && mem_rsp.valid;

  // Combinational miss blocks the next acceptance in the same cycle
  assign stall = ld_miss || (state_q == StRefill);

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle:   if (ld_miss) state_d = StRefill;
      StRefill: if (mem_rsp.valid) state_d = StIdle;
      default:  state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // Valid bits are cleared by the sweep invalidate and set by a refill
  always_ff @(posedge clk_i) begin
    if (inv) begin
      valid_q[inv_idx] <= 1'b0;
    end else if (fill) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // Refill writes tag and data while a store hit writes only the data word
  always_ff @(posedge clk_i) begin
    if (fill) begin
      tag_q[idx]  <= dec_op.addr.fields.tag;
      data_q[idx] <= mem_rsp.data;
    end else if (do_op && dec_op.we && hit) begin
      data_q[idx] <= dec_op.wdata;
    end
  end

  // Response for load hits and all stores
  // Held load after a refill comes back here as a hit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= do_op && (dec_op.we || hit);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_op) begin
      rsp_ack_q  <= dec_op.we;
      rsp_data_q <= dec_op.we ? dec_op.wdata : data_q[idx];
    end
  end

  assign hit_op = '{valid: rsp_vld_q, ack: rsp_ack_q, rdata: rsp_data_q};

  // Memory strobe for every store and for each load miss
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_vld_q <= 1'b0;
    end else begin
      mem_vld_q <= do_op && (dec_op.we || !hit);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_op) begin
      mem_we_q   <= dec_op.we;
      mem_addr_q <= dec_op.addr.raw;
      mem_data_q <= dec_op.wdata;
    end
  end

  assign mem_req = '{valid: mem_vld_q, we: mem_we_q, addr: mem_addr_q, data: mem_data_q};

  // A memory return arrives only while a refill waits
  a_rsp_in_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rsp.valid |-> state_q == StRefill);

  // One read per refill
  a_single_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == StRefill && $past(state_q) == StRefill) |-> !(mem_req.valid && !mem_req.we));

endmodule

/* source/dcache_req_decode.sv */
// Data cache front stage
// Arbitrates sweep against CPU, decodes the address and registers the op

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_req_decode
  import dcache_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  cpu_req_t                 cpu_req,
  input  rst_req_t                 rst_req,
  input  logic                     stall,
  output logic                     busy,
  output dec_op_t                  dec_op,
  output logic                     inv,
  output logic [`DCACHE_IDX_W-1:0] inv_idx
);

  logic                      accept;
  logic                      op_valid_q;
  logic                      op_we_q;
  dcache_addr_u              op_addr_q;
  logic [`DCACHE_WORD_W-1:0] op_wdata_q;

  // Sweep invalidates go straight to the arrays
  assign inv     = rst_req.valid;
  assign inv_idx = rst_req.idx;

  // CPU waits during the sweep and during a refill
  assign busy   = rst_req.valid | stall;
  assign accept = cpu_req.valid & ~busy;

  // Op valid, held while the lookup stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else if (!stall) begin
      op_valid_q <= accept;
    end
  end

  // Op payload, loaded only on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_we_q       <= cpu_req.we;
      // Raw view written here, lookup reads the field view
      op_addr_q.raw <= cpu_req.addr;
      op_wdata_q    <= cpu_req.wdata;
    end
  end

  assign dec_op = '{
    valid: op_valid_q,
    we:    op_we_q,
    addr:  op_addr_q,
    wdata: op_wdata_q
  };

  // A missing load is replayed from this register after the refill
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall |=> $stable(dec_op));

endmodule

/* source/dcache_rst_block.sv */
// Data cache reset sweep
// Walks every set once after reset and asks for its invalidation

`timescale 1ns/1ps
`include "dcache_macros.svh"

module dcache_rst_block
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  output rst_req_t rst_req
);

  // Index of the last set in the sweep
  localparam logic [`DCACHE_IDX_W-1:0] LastIdx = `DCACHE_IDX_W'(`DCACHE_SETS - 1);

  typedef enum logic {
    StReset,
    StDone
  } state_t;

  state_t                   state_d, state_q;
  logic [`DCACHE_IDX_W-1:0] cnt_q;
  logic                     tc;

  // Set counter runs only during the sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (state_q == StReset) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tc = (cnt_q == LastIdx);

  // Leave the sweep at the terminal count
  always_comb begin
    state_d = state_q;
    if (state_q == StReset && tc) begin
      state_d = StDone;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StReset;
    end else begin
      state_q <= state_d;
    end
  end

  assign rst_req = '{valid: (state_q == StReset), idx: cnt_q};

  // Sweep is a single pass
  a_no_restart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rst_req.valid |=> !rst_req.valid);

endmodule

/* source/dcache_pkg.sv */
// Data cache types
// Address views and the structs passed between cache stages

`include "dcache_macros.svh"

package dcache_pkg;

  // One byte address, read raw toward memory or split for the lookup
  typedef union packed {
    logic [`DCACHE_WORD_W-1:0] raw;
    struct packed {
      logic [`DCACHE_TAG_W-1:0] tag;
      logic [`DCACHE_IDX_W-1:0] idx;
      logic [`DCACHE_OFF_W-1:0] off;
    } fields;
  } dcache_addr_u;

  // CPU request, held by the CPU while busy
  typedef struct packed {
    logic                      valid;
    logic                      we;
    logic [`DCACHE_WORD_W-1:0] addr;
    logic [`DCACHE_WORD_W-1:0] wdata;
  } cpu_req_t;

  // Response toward the CPU, ack marks a finished store
  typedef struct packed {
    logic                      valid;
    logic                      ack;
    logic [`DCACHE_WORD_W-1:0] rdata;
  } cpu_rsp_t;

  // Operation registered by decode
  typedef struct packed {
    logic                      valid;
    logic                      we;
    dcache_addr_u              addr;
    logic [`DCACHE_WORD_W-1:0] wdata;
  } dec_op_t;

  // Invalidate request from the reset sweep
  typedef struct packed {
    logic                     valid;
    logic [`DCACHE_IDX_W-1:0] idx;
  } rst_req_t;

  // Memory side, read strobes get one return, writes are posted
  typedef struct packed {
    logic                      valid;
    logic                      we;
    logic [`DCACHE_WORD_W-1:0] addr;
    logic [`DCACHE_WORD_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                      valid;
    logic [`DCACHE_WORD_W-1:0] data;
  } mem_rsp_t;

endpackage

/* source/dcache_macros.svh */
// Data cache sizes
// Direct-mapped, one 32-bit word per line

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Data word and byte address width
`define DCACHE_WORD_W 32

// Set index width, 16 sets
`define DCACHE_IDX_W 4

// Number of sets, also the length of the reset sweep
`define DCACHE_SETS 16

// Byte offset inside a word
`define DCACHE_OFF_W 2

// Tag is what is left of the address
`define DCACHE_TAG_W 26

`endif
